//--- rtl/stall_pkg.sv
package stall_pkg;

   // AXI bus widths
   localparam int addr_w = 32;
   localparam int data_w = 64;
   localparam int strb_w = data_w / 8;
   localparam int id_w   = 4;
   localparam int len_w  = 8;

   // 4 KB pages, the offset below page_lsb is never translated
   localparam int page_lsb = 12;
   localparam int ppn_w    = addr_w - page_lsb;

   // Translation table geometry
   localparam int tbl_entries = 8;
   localparam int tbl_idx_w   = 3;

   // B channel response codes
   localparam logic [1:0] resp_okay   = 2'b00;
   localparam logic [1:0] resp_slverr = 2'b10;

   // One single-beat write, address and data merged
   typedef struct packed {
      logic [id_w-1:0]   id;
      logic [addr_w-1:0] addr;
      logic [data_w-1:0] data;
      logic [strb_w-1:0] strb;
   } wr_req_t;

   // Page lookup request toward the table
   typedef struct packed {
      logic             valid;
      logic [ppn_w-1:0] hppa;
   } cpu_reqpkt_t;

   // Lookup answer, ppa only meaningful with allow_access set
   typedef struct packed {
      logic             allow_access;
      logic [ppn_w-1:0] ppa;
   } hawk_cpu_ovrd_pkt_t;

   // Table entry write from the configuration side
   typedef struct packed {
      logic                 valid;
      logic [tbl_idx_w-1:0] idx;
      logic [ppn_w-1:0]     hppa;
      logic [ppn_w-1:0]     ppa;
      logic                 allow;
   } tbl_cfg_t;

endpackage

//--- rtl/wr_capture.sv
`timescale 1ns/1ns

module wr_capture import stall_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  logic [id_w-1:0]   s_awid,
   input  logic [addr_w-1:0] s_awaddr,
   input  logic [len_w-1:0]  s_awlen,
   input  logic              s_awvalid,
   output logic              s_awready,
   input  logic [data_w-1:0] s_wdata,
   input  logic [strb_w-1:0] s_wstrb,
   input  logic              s_wlast,
   input  logic              s_wvalid,
   output logic              s_wready,
   output wr_req_t           cap_req,
   output logic              cap_valid,
   input  logic              cap_ready
);

   logic              aw_have;
   logic              w_have;
   logic [id_w-1:0]   aw_id_q;
   logic [addr_w-1:0] aw_addr_q;
   logic [data_w-1:0] w_data_q;
   logic [strb_w-1:0] w_strb_q;

   // Each channel has its own holding flag, so AW and W may come in any order
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         aw_have   <= 1'b0;
         w_have    <= 1'b0;
         cap_valid <= 1'b0;
         s_awready <= 1'b0;
         s_wready  <= 1'b0;
      end else if (cap_valid && cap_ready) begin
         // Merged request taken so both channels open again
         aw_have   <= 1'b0;
         w_have    <= 1'b0;
         cap_valid <= 1'b0;
         s_awready <= 1'b1;
         s_wready  <= 1'b1;
      end else begin
         if (s_awvalid && s_awready) begin
            aw_have   <= 1'b1;
            s_awready <= 1'b0;
         end else if (!aw_have) begin
            s_awready <= 1'b1;
         end
         if (s_wvalid && s_wready) begin
            w_have   <= 1'b1;
            s_wready <= 1'b0;
         end else if (!w_have) begin
            s_wready <= 1'b1;
         end
         // Present one cycle after the second beat lands
         cap_valid <= aw_have && w_have;
      end
   end

   always_ff @(posedge clk) begin
      if (s_awvalid && s_awready) begin
         aw_id_q   <= s_awid;
         aw_addr_q <= s_awaddr;
      end
      if (s_wvalid && s_wready) begin
         w_data_q <= s_wdata;
         w_strb_q <= s_wstrb;
      end
   end

   always_comb begin
      cap_req.id   = aw_id_q;
      cap_req.addr = aw_addr_q;
      cap_req.data = w_data_q;
      cap_req.strb = w_strb_q;
   end

   // Only single-beat writes are supported by the stall path
   a_single_awlen: assert property (@(posedge clk) disable iff (rst)
      (s_awvalid && s_awready) |-> (s_awlen == '0));

   a_single_wlast: assert property (@(posedge clk) disable iff (rst)
      (s_wvalid && s_wready) |-> s_wlast);

endmodule

//--- rtl/page_lookup.sv
`timescale 1ns/1ns

module page_lookup import stall_pkg::*; (
   input  logic               clk,
   input  logic               rst,
   input  tbl_cfg_t           cfg,
   input  cpu_reqpkt_t        cpu_reqpkt,
   output hawk_cpu_ovrd_pkt_t hawk_cpu_ovrd_pkt
);

   logic [tbl_entries-1:0] tbl_valid;
   logic [tbl_entries-1:0] tbl_allow;
   logic [ppn_w-1:0]       tbl_hppa [tbl_entries];
   logic [ppn_w-1:0]       tbl_ppa  [tbl_entries];

   logic [tbl_entries-1:0] match_vec;
   logic                   hit;
   logic [ppn_w-1:0]       hit_ppa;
   logic                   allow_q;
   logic [ppn_w-1:0]       ppa_q;

   // Entries only ever become valid, rewriting an index replaces it
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         tbl_valid <= '0;
      end else if (cfg.valid) begin
         tbl_valid[cfg.idx] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (cfg.valid) begin
         tbl_hppa[cfg.idx]  <= cfg.hppa;
         tbl_ppa[cfg.idx]   <= cfg.ppa;
         tbl_allow[cfg.idx] <= cfg.allow;
      end
   end

   // Full associative search against the requested host page
   always_comb begin
      match_vec = '0;
      hit       = 1'b0;
      hit_ppa   = '0;
      for (int i = 0; i < tbl_entries; i++) begin
         match_vec[i] = tbl_valid[i] && (tbl_hppa[i] == cpu_reqpkt.hppa);
         if (match_vec[i] && tbl_allow[i]) begin
            hit     = 1'b1;
            hit_ppa = tbl_ppa[i];
         end
      end
   end

   // Answer is registered, one cycle behind the request
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         allow_q <= 1'b0;
      end else begin
         allow_q <= cpu_reqpkt.valid && hit;
      end
   end

   always_ff @(posedge clk) begin
      ppa_q <= hit_ppa;
   end

   assign hawk_cpu_ovrd_pkt.allow_access = allow_q;
   assign hawk_cpu_ovrd_pkt.ppa          = ppa_q;

   // Config side must not leave two live entries for one host page
   a_unique_hppa: assert property (@(posedge clk) disable iff (rst)
      cpu_reqpkt.valid |-> $onehot0(match_vec));

endmodule

//--- rtl/cpu_stall_wr.sv
`timescale 1ns/1ns

module cpu_stall_wr import stall_pkg::*; (
   input  logic               clk,
   input  logic               rst,
   input  wr_req_t            cap_req,
   input  logic               cap_valid,
   output logic               cap_ready,
   input  logic               hawk_inactive,
   output cpu_reqpkt_t        cpu_reqpkt,
   input  hawk_cpu_ovrd_pkt_t hawk_cpu_ovrd_pkt,
   output wr_req_t            rel_req,
   output logic               rel_valid,
   input  logic               rel_ready
);

   typedef enum logic [1:0] {
      st_idle,
      st_wait,
      st_release
   } state_t;

   state_t  state;
   wr_req_t req_q;
   logic    granted;

   assign granted = (state == st_wait) && hawk_cpu_ovrd_pkt.allow_access;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle: begin
               // With the manager off the write goes out untranslated
               if (cap_valid) begin
                  state <= hawk_inactive ? st_release : st_wait;
               end
            end
            st_wait: begin
               if (granted) begin
                  state <= st_release;
               end
            end
            st_release: begin
               if (rel_ready) begin
                  state <= st_idle;
               end
            end
            default: begin
               state <= st_idle;
            end
         endcase
      end
   end

   // Held write whose page bits are swapped in place once the table grants
   always_ff @(posedge clk) begin
      if (cap_valid && cap_ready) begin
         req_q <= cap_req;
      end else if (granted) begin
         req_q.addr <= {hawk_cpu_ovrd_pkt.ppa, req_q.addr[page_lsb-1:0]};
      end
   end

   assign cap_ready = (state == st_idle);

   // Lookup repeats each cycle until a grant comes back
   // so a missing page just keeps asking
   assign cpu_reqpkt.valid = (state == st_wait) && !hawk_cpu_ovrd_pkt.allow_access;
   assign cpu_reqpkt.hppa  = req_q.addr[addr_w-1:page_lsb];

   assign rel_valid = (state == st_release);
   assign rel_req   = req_q;

   // A grant only answers a lookup issued the cycle before
   a_grant_follows_req: assert property (@(posedge clk) disable iff (rst)
      hawk_cpu_ovrd_pkt.allow_access |-> $past(cpu_reqpkt.valid));

endmodule

//--- rtl/wr_issue.sv
`timescale 1ns/1ns

module wr_issue import stall_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  wr_req_t           rel_req,
   input  logic              rel_valid,
   output logic              rel_ready,
   output logic [id_w-1:0]   m_awid,
   output logic [addr_w-1:0] m_awaddr,
   output logic [len_w-1:0]  m_awlen,
   output logic              m_awvalid,
   input  logic              m_awready,
   output logic [data_w-1:0] m_wdata,
   output logic [strb_w-1:0] m_wstrb,
   output logic              m_wlast,
   output logic              m_wvalid,
   input  logic              m_wready,
   input  logic [id_w-1:0]   m_bid,
   input  logic [1:0]        m_bresp,
   input  logic              m_bvalid,
   output logic              m_bready,
   output logic [id_w-1:0]   s_bid,
   output logic [1:0]        s_bresp,
   output logic              s_bvalid,
   input  logic              s_bready
);

   wr_req_t req_q;

   // Next request only once both channels have handed off
   assign rel_ready = !m_awvalid && !m_wvalid;

   // AW and W complete independently, each valid clears on its own ready
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         m_awvalid <= 1'b0;
         m_wvalid  <= 1'b0;
      end else if (rel_valid && rel_ready) begin
         m_awvalid <= 1'b1;
         m_wvalid  <= 1'b1;
      end else begin
         if (m_awready) begin
            m_awvalid <= 1'b0;
         end
         if (m_wready) begin
            m_wvalid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rel_valid && rel_ready) begin
         req_q <= rel_req;
      end
   end

   assign m_awid   = req_q.id;
   assign m_awaddr = req_q.addr;
   assign m_awlen  = '0;
   assign m_wdata  = req_q.data;
   assign m_wstrb  = req_q.strb;
   assign m_wlast  = 1'b1;

   // Write response goes straight back to the CPU
   assign s_bid    = m_bid;
   assign s_bresp  = m_bresp;
   assign s_bvalid = m_bvalid;
   assign m_bready = s_bready;

   a_bresp_code: assert property (@(posedge clk) disable iff (rst)
      m_bvalid |-> (m_bresp == resp_okay || m_bresp == resp_slverr));

endmodule

//--- rtl/stall_top.sv
`timescale 1ns/1ns

module stall_top import stall_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   // CPU side
   input  logic [id_w-1:0]   s_awid,
   input  logic [addr_w-1:0] s_awaddr,
   input  logic [len_w-1:0]  s_awlen,
   input  logic              s_awvalid,
   output logic              s_awready,
   input  logic [data_w-1:0] s_wdata,
   input  logic [strb_w-1:0] s_wstrb,
   input  logic              s_wlast,
   input  logic              s_wvalid,
   output logic              s_wready,
   output logic [id_w-1:0]   s_bid,
   output logic [1:0]        s_bresp,
   output logic              s_bvalid,
   input  logic              s_bready,
   // Memory side
   output logic [id_w-1:0]   m_awid,
   output logic [addr_w-1:0] m_awaddr,
   output logic [len_w-1:0]  m_awlen,
   output logic              m_awvalid,
   input  logic              m_awready,
   output logic [data_w-1:0] m_wdata,
   output logic [strb_w-1:0] m_wstrb,
   output logic              m_wlast,
   output logic              m_wvalid,
   input  logic              m_wready,
   input  logic [id_w-1:0]   m_bid,
   input  logic [1:0]        m_bresp,
   input  logic              m_bvalid,
   output logic              m_bready,
   // Page manager stand-in
   input  tbl_cfg_t          cfg,
   input  logic              hawk_inactive
);

   wr_req_t            cap_req;
   logic               cap_valid;
   logic               cap_ready;
   cpu_reqpkt_t        cpu_reqpkt;
   hawk_cpu_ovrd_pkt_t hawk_cpu_ovrd_pkt;
   wr_req_t            rel_req;
   logic               rel_valid;
   logic               rel_ready;

   wr_capture u_capture (
      .clk       (clk),
      .rst       (rst),
      .s_awid    (s_awid),
      .s_awaddr  (s_awaddr),
      .s_awlen   (s_awlen),
      .s_awvalid (s_awvalid),
      .s_awready (s_awready),
      .s_wdata   (s_wdata),
      .s_wstrb   (s_wstrb),
      .s_wlast   (s_wlast),
      .s_wvalid  (s_wvalid),
      .s_wready  (s_wready),
      .cap_req   (cap_req),
      .cap_valid (cap_valid),
      .cap_ready (cap_ready)
   );

   cpu_stall_wr u_stall (
      .clk               (clk),
      .rst               (rst),
      .cap_req           (cap_req),
      .cap_valid         (cap_valid),
      .cap_ready         (cap_ready),
      .hawk_inactive     (hawk_inactive),
      .cpu_reqpkt        (cpu_reqpkt),
      .hawk_cpu_ovrd_pkt (hawk_cpu_ovrd_pkt),
      .rel_req           (rel_req),
      .rel_valid         (rel_valid),
      .rel_ready         (rel_ready)
   );

   page_lookup u_lookup (
      .clk               (clk),
      .rst               (rst),
      .cfg               (cfg),
      .cpu_reqpkt        (cpu_reqpkt),
      .hawk_cpu_ovrd_pkt (hawk_cpu_ovrd_pkt)
   );

   wr_issue u_issue (
      .clk       (clk),
      .rst       (rst),
      .rel_req   (rel_req),
      .rel_valid (rel_valid),
      .rel_ready (rel_ready),
      .m_awid    (m_awid),
      .m_awaddr  (m_awaddr),
      .m_awlen   (m_awlen),
      .m_awvalid (m_awvalid),
      .m_awready (m_awready),
      .m_wdata   (m_wdata),
      .m_wstrb   (m_wstrb),
      .m_wlast   (m_wlast),
      .m_wvalid  (m_wvalid),
      .m_wready  (m_wready),
      .m_bid     (m_bid),
      .m_bresp   (m_bresp),
      .m_bvalid  (m_bvalid),
      .m_bready  (m_bready),
      .s_bid     (s_bid),
      .s_bresp   (s_bresp),
      .s_bvalid  (s_bvalid),
      .s_bready  (s_bready)
   );

endmodule

//--- include/stall_tb_tasks.svh
`ifndef STALL_TB_TASKS_SVH
`define STALL_TB_TASKS_SVH

// Stop at the first mismatch
task automatic report_fail(input string msg);
   $display("[FAIL] %0t: %s", $time, msg);
   $display("Errors found");
   $fatal(1, "%s", msg);
endtask

// Readable form of one write for log lines
function automatic string fmt_req(input stall_pkg::wr_req_t r);
   return $sformatf("id=%0h addr=%08h data=%016h strb=%02h", r.id, r.addr, r.data, r.strb);
endfunction

// Memory-side AW and W payload folded back into one request
function automatic stall_pkg::wr_req_t mon_req(
   input logic [stall_pkg::id_w-1:0]   id,
   input logic [stall_pkg::addr_w-1:0] addr,
   input logic [stall_pkg::data_w-1:0] data,
   input logic [stall_pkg::strb_w-1:0] strb
);
   stall_pkg::wr_req_t r;
   r.id   = id;
   r.addr = addr;
   r.data = data;
   r.strb = strb;
   return r;
endfunction

task automatic check_req(input stall_pkg::wr_req_t exp, input stall_pkg::wr_req_t got);
   if (got !== exp) begin
      report_fail($sformatf("write mismatch, expected %s, got %s", fmt_req(exp), fmt_req(got)));
   end
endtask

task automatic check_b(
   input logic [stall_pkg::id_w-1:0] exp_id,
   input logic [1:0]                 exp_resp,
   input logic [stall_pkg::id_w-1:0] got_id,
   input logic [1:0]                 got_resp
);
   if (got_id !== exp_id || got_resp !== exp_resp) begin
      report_fail($sformatf("B mismatch, expected id=%0h resp=%0h, got id=%0h resp=%0h",
                            exp_id, exp_resp, got_id, got_resp));
   end
endtask

`endif

//--- tb/tb_stall_top.sv
`timescale 1ns/1ns

module tb_stall_top import stall_pkg::*; ();

   localparam int clk_period     = 10;
   localparam int reset_cycles   = 8;
   localparam int num_vec        = 10;
   localparam int timeout_cycles = num_vec * 200 + reset_cycles;

   localparam logic [1:0] cfg_none     = 2'd0;
   localparam logic [1:0] cfg_before   = 2'd1;
   localparam logic [1:0] cfg_after    = 2'd2;
   localparam logic [1:0] ord_aw_first = 2'd0;
   localparam logic [1:0] ord_w_first  = 2'd1;
   localparam logic [1:0] ord_same     = 2'd2;

   // One table row per CPU write
   typedef struct packed {
      logic [id_w-1:0]   id;
      logic [addr_w-1:0] addr;
      logic [data_w-1:0] data;
      logic [strb_w-1:0] strb;
      logic              inactive;
      logic [1:0]        cfg_mode;
      tbl_cfg_t          cfg;
      logic [7:0]        cfg_delay;
      logic [1:0]        order;
      logic [3:0]        aw_stall;
      logic [3:0]        w_stall;
      logic [1:0]        bresp;
      logic [addr_w-1:0] exp_addr;
   } vec_t;

   logic              clk = 1'b0;
   logic              rst = 1'b1;
   logic [id_w-1:0]   s_awid;
   logic [addr_w-1:0] s_awaddr;
   logic [len_w-1:0]  s_awlen;
   logic              s_awvalid;
   logic              s_awready;
   logic [data_w-1:0] s_wdata;
   logic [strb_w-1:0] s_wstrb;
   logic              s_wlast;
   logic              s_wvalid;
   logic              s_wready;
   logic [id_w-1:0]   s_bid;
   logic [1:0]        s_bresp;
   logic              s_bvalid;
   logic              s_bready;
   logic [id_w-1:0]   m_awid;
   logic [addr_w-1:0] m_awaddr;
   logic [len_w-1:0]  m_awlen;
   logic              m_awvalid;
   logic              m_awready;
   logic [data_w-1:0] m_wdata;
   logic [strb_w-1:0] m_wstrb;
   logic              m_wlast;
   logic              m_wvalid;
   logic              m_wready;
   logic [id_w-1:0]   m_bid;
   logic [1:0]        m_bresp;
   logic              m_bvalid;
   logic              m_bready;
   tbl_cfg_t          cfg;
   logic              hawk_inactive;

   vec_t   vecs [num_vec];
   int     aw_extra [num_vec];
   int     w_extra [num_vec];
   integer seed = 32'h7e1a26a5;
   int     aw_cnt = 0;
   int     w_cnt = 0;
   int     got_cnt = 0;
   int     b_cnt = 0;

   logic [id_w+addr_w-1:0]   aw_q [$];
   logic [data_w+strb_w-1:0] w_q [$];

   `include "stall_tb_tasks.svh"

   stall_top dut0 (.*);

   always #(clk_period / 2) clk = ~clk;

   function automatic tbl_cfg_t make_cfg(
      input logic [tbl_idx_w-1:0] idx,
      input logic [ppn_w-1:0]     hppa,
      input logic [ppn_w-1:0]     ppa,
      input logic                 allow
   );
      tbl_cfg_t c;
      c.valid = 1'b1;
      c.idx   = idx;
      c.hppa  = hppa;
      c.ppa   = ppa;
      c.allow = allow;
      return c;
   endfunction

   // Expected addresses carry ppa in the page bits and keep the offset
   task automatic load_table();
      vecs[0] = '{4'h1, 32'h0004_5a38, 64'h0011_2233_4455_6677, 8'hff, 1'b1, cfg_before,
                  make_cfg(3'd0, 20'h00045, 20'h81234, 1'b1), 8'd0, ord_aw_first,
                  4'd0, 4'd0, resp_okay, 32'h0004_5a38};
      vecs[1] = '{4'h2, 32'h1234_5678, 64'h8899_aabb_ccdd_eeff, 8'h0f, 1'b1, cfg_none,
                  '0, 8'd0, ord_w_first, 4'd2, 4'd0, resp_slverr, 32'h1234_5678};
      vecs[2] = '{4'h3, 32'h0004_5ffc, 64'hdead_beef_0000_0001, 8'hf0, 1'b0, cfg_none,
                  '0, 8'd0, ord_same, 4'd1, 4'd3, resp_okay, 32'h8123_4ffc};
      vecs[3] = '{4'h4, 32'h7fff_0008, 64'h0123_4567_89ab_cdef, 8'h3c, 1'b0, cfg_before,
                  make_cfg(3'd1, 20'h7fff0, 20'h00abc, 1'b1), 8'd0, ord_w_first,
                  4'd0, 4'd2, resp_okay, 32'h00ab_c008};
      // Entry for page 0x00200 goes in disallowed
      vecs[4] = '{4'h5, 32'h7fff_0ff0, 64'hfedc_ba98_7654_3210, 8'h81, 1'b0, cfg_before,
                  make_cfg(3'd2, 20'h00200, 20'h3c3c3, 1'b0), 8'd0, ord_aw_first,
                  4'd4, 4'd1, resp_slverr, 32'h00ab_cff0};
      vecs[5] = '{4'h6, 32'h0020_0a00, 64'h5555_aaaa_5555_aaaa, 8'hff, 1'b0, cfg_after,
                  make_cfg(3'd2, 20'h00200, 20'h3c3c3, 1'b1), 8'd20, ord_same,
                  4'd0, 4'd0, resp_slverr, 32'h3c3c_3a00};
      // Page with no entry at all
      vecs[6] = '{4'h7, 32'h0abc_d123, 64'h1357_9bdf_2468_ace0, 8'h01, 1'b0, cfg_after,
                  make_cfg(3'd3, 20'h0abcd, 20'h55aa5, 1'b1), 8'd15, ord_aw_first,
                  4'd1, 4'd1, resp_okay, 32'h55aa_5123};
      vecs[7] = '{4'h8, 32'h0004_5000, 64'h0f0f_0f0f_f0f0_f0f0, 8'hcc, 1'b0, cfg_none,
                  '0, 8'd0, ord_w_first, 4'd3, 4'd1, resp_okay, 32'h8123_4000};
      vecs[8] = '{4'h9, 32'h0020_0004, 64'h7777_8888_9999_aaaa, 8'h55, 1'b0, cfg_none,
                  '0, 8'd0, ord_same, 4'd0, 4'd4, resp_slverr, 32'h3c3c_3004};
      vecs[9] = '{4'ha, 32'hdead_b0e8, 64'h0000_ffff_0000_ffff, 8'haa, 1'b1, cfg_none,
                  '0, 8'd0, ord_aw_first, 4'd2, 4'd2, resp_okay, 32'hdead_b0e8};
      for (int k = 0; k < num_vec; k++) begin
         aw_extra[k] = $unsigned($random(seed)) % 4;
         w_extra[k]  = $unsigned($random(seed)) % 4;
      end
   endtask

   task automatic check_idle(input string when);
      if (m_awvalid !== 1'b0 || m_wvalid !== 1'b0 || s_bvalid !== 1'b0 ||
          s_awready !== 1'b0 || s_wready !== 1'b0) begin
         report_fail($sformatf("outputs not idle %s", when));
      end
   endtask

   // CPU-side drivers start and end 1 ns after a rising edge
   task automatic send_aw(input int k, input int lag);
      repeat (lag) begin
         @(posedge clk);
         #1;
      end
      s_awid    = vecs[k].id;
      s_awaddr  = vecs[k].addr;
      s_awlen   = '0;
      s_awvalid = 1'b1;
      @(negedge clk);
      while (s_awready !== 1'b1) @(negedge clk);
      @(posedge clk);
      #1;
      s_awvalid = 1'b0;
   endtask

   task automatic send_w(input int k, input int lag);
      repeat (lag) begin
         @(posedge clk);
         #1;
      end
      s_wdata  = vecs[k].data;
      s_wstrb  = vecs[k].strb;
      s_wlast  = 1'b1;
      s_wvalid = 1'b1;
      @(negedge clk);
      while (s_wready !== 1'b1) @(negedge clk);
      @(posedge clk);
      #1;
      s_wvalid = 1'b0;
   endtask

   task automatic send_write(input int k);
      int aw_lag;
      int w_lag;
      aw_lag = (vecs[k].order == ord_w_first) ? 2 : 0;
      w_lag  = (vecs[k].order == ord_aw_first) ? 2 : 0;
      fork
         send_aw(k, aw_lag);
         send_w(k, w_lag);
      join
   endtask

   task automatic apply_cfg(input int k);
      cfg = vecs[k].cfg;
      @(posedge clk);
      #1;
      cfg = '0;
   endtask

   // Mode changes only once earlier writes have left the stall stage
   task automatic wait_drained(input int k);
      while (aw_cnt < k || w_cnt < k) begin
         @(posedge clk);
         #1;
      end
   endtask

   initial begin : stimulus
      s_awid        = '0;
      s_awaddr      = '0;
      s_awlen       = '0;
      s_awvalid     = 1'b0;
      s_wdata       = '0;
      s_wstrb       = '0;
      s_wlast       = 1'b0;
      s_wvalid      = 1'b0;
      cfg           = '0;
      hawk_inactive = 1'b0;
      load_table();
      repeat (4) @(posedge clk);
      @(negedge clk);
      check_idle("during reset");
      repeat (reset_cycles - 4) @(posedge clk);
      #1;
      rst = 1'b0;
      @(negedge clk);
      check_idle("right after reset");
      @(posedge clk);
      #1;
      for (int k = 0; k < num_vec; k++) begin
         if (vecs[k].inactive !== hawk_inactive) begin
            wait_drained(k);
            hawk_inactive = vecs[k].inactive;
         end
         if (vecs[k].cfg_mode == cfg_before) begin
            apply_cfg(k);
         end
         send_write(k);
         if (vecs[k].cfg_mode == cfg_after) begin
            repeat (vecs[k].cfg_delay) @(posedge clk);
            #1;
            if (aw_cnt > k || w_cnt > k) begin
               report_fail($sformatf("write %0d issued before its page was granted", k));
            end
            apply_cfg(k);
         end
      end
      while (got_cnt < num_vec || b_cnt < num_vec) @(posedge clk);
      // Idle tail to catch duplicates
      repeat (20) @(posedge clk);
      if (got_cnt != num_vec || b_cnt != num_vec || aw_cnt != num_vec || w_cnt != num_vec) begin
         report_fail($sformatf("counts off at end, writes %0d responses %0d of %0d",
                               got_cnt, b_cnt, num_vec));
      end else begin
         $display("No errors");
         $finish;
      end
   end

   // CPU side holds B back now and then
   initial begin : b_ready_driver
      s_bready = 1'b1;
      forever begin
         @(posedge clk);
         #1;
         s_bready = ($unsigned($random(seed)) % 4) != 0;
      end
   end

   // Memory-side ready with table stall plus a random extra
   initial begin : aw_responder
      int stall;
      m_awready = 1'b0;
      for (int k = 0; k < num_vec; k++) begin
         @(negedge clk);
         while (m_awvalid !== 1'b1) @(negedge clk);
         stall = vecs[k].aw_stall + aw_extra[k];
         repeat (stall) @(posedge clk);
         @(posedge clk);
         #1;
         m_awready = 1'b1;
         @(posedge clk);
         #1;
         m_awready = 1'b0;
      end
   end

   initial begin : w_responder
      int stall;
      m_wready = 1'b0;
      for (int k = 0; k < num_vec; k++) begin
         @(negedge clk);
         while (m_wvalid !== 1'b1) @(negedge clk);
         stall = vecs[k].w_stall + w_extra[k];
         repeat (stall) @(posedge clk);
         @(posedge clk);
         #1;
         m_wready = 1'b1;
         @(posedge clk);
         #1;
         m_wready = 1'b0;
      end
   end

   // B goes back only after both beats of that write were taken
   initial begin : b_responder
      m_bvalid = 1'b0;
      m_bid    = '0;
      m_bresp  = resp_okay;
      for (int k = 0; k < num_vec; k++) begin
         @(posedge clk);
         while (aw_cnt <= k || w_cnt <= k) @(posedge clk);
         #1;
         m_bid    = vecs[k].id;
         m_bresp  = vecs[k].bresp;
         m_bvalid = 1'b1;
         @(negedge clk);
         while (m_bready !== 1'b1) @(negedge clk);
         @(posedge clk);
         #1;
         m_bvalid = 1'b0;
      end
   end

   // A handshake sampled mid-cycle completes at the next edge
   always @(negedge clk) begin : scoreboard
      wr_req_t                  exp_req;
      logic [id_w+addr_w-1:0]   aw_beat;
      logic [data_w+strb_w-1:0] w_beat;
      if (!rst) begin
         if (m_bready !== s_bready) begin
            report_fail($sformatf("m_bready %b while s_bready is %b", m_bready, s_bready));
         end
         if (m_awvalid === 1'b1 && m_awready === 1'b1) begin
            if (m_awlen !== '0) begin
               report_fail($sformatf("m_awlen %0d on a single-beat write", m_awlen));
            end
            aw_q.push_back({m_awid, m_awaddr});
            aw_cnt++;
         end
         if (m_wvalid === 1'b1 && m_wready === 1'b1) begin
            if (m_wlast !== 1'b1) begin
               report_fail("m_wlast low on a single-beat write");
            end
            w_q.push_back({m_wdata, m_wstrb});
            w_cnt++;
         end
         if (aw_q.size() > 0 && w_q.size() > 0) begin
            if (got_cnt >= num_vec) begin
               report_fail("memory side issued more writes than were sent");
            end
            aw_beat      = aw_q.pop_front();
            w_beat       = w_q.pop_front();
            exp_req.id   = vecs[got_cnt].id;
            exp_req.addr = vecs[got_cnt].exp_addr;
            exp_req.data = vecs[got_cnt].data;
            exp_req.strb = vecs[got_cnt].strb;
            check_req(exp_req, mon_req(aw_beat[addr_w +: id_w], aw_beat[addr_w-1:0],
                                       w_beat[strb_w +: data_w], w_beat[strb_w-1:0]));
            got_cnt++;
         end
         if (s_bvalid === 1'b1 && s_bready === 1'b1) begin
            if (b_cnt >= num_vec) begin
               report_fail("CPU side saw more write responses than were sent");
            end
            check_b(vecs[b_cnt].id, vecs[b_cnt].bresp, s_bid, s_bresp);
            b_cnt++;
         end
      end
   end

   initial begin : watchdog
      #(timeout_cycles * clk_period);
      $display("Run timed out after %0d cycles with writes still pending", timeout_cycles);
      $display("Errors found");
      $fatal(1, "timeout");
   end

endmodule

//--- flist.f
+incdir+include
rtl/stall_pkg.sv
rtl/wr_capture.sv
rtl/page_lookup.sv
rtl/cpu_stall_wr.sv
rtl/wr_issue.sv
rtl/stall_top.sv
tb/tb_stall_top.sv

//--- Makefile
TOP := tb_stall_top

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "^No errors$$" sim.log && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir sim.log
